/* lar_file.f */
+incdir+include
src/lar_file_pkg.sv
src/lar_tag_search.sv
src/lar_tag_stack.sv
src/lar_shared_store.sv
src/lar_metadata_file.sv
src/lar_write_ctrl.sv
src/lar_file_top.sv
bench/lar_file_checker.sv
bench/lar_file_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= lar_file_tb
FILELIST ?= lar_file.f
BUILD ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* include/lar_file_model.svh */
`ifndef LAR_FILE_MODEL_SVH
`define LAR_FILE_MODEL_SVH

// reference state, absolute counts and a plain stack
lar_meta_t m_meta [LAR_NUM_DEFAULT];
lar_shared_t m_pool [LAR_NUM_DEFAULT];
lar_tag_t m_stack [LAR_NUM_DEFAULT];
lar_tag_t m_ptr;

function automatic void model_reset();
	for (int i = 0; i < LAR_NUM_DEFAULT; i++)
	begin
		m_meta[i] = '0;
		m_pool[i] = '0;
		m_stack[i] = lar_tag_t'(i);
	end
	m_ptr = lar_tag_t'(LAR_NUM_DEFAULT - 1);
endfunction

function automatic lar_rd_t model_read(lar_idx_t idx);
	lar_rd_t r;
	r.data = m_pool[m_meta[idx].tag].data;
	r.addr = m_meta[idx].addr;
	r.tag = m_meta[idx].tag;
	r.data_type = m_meta[idx].data_type;
	r.int_size = m_meta[idx].int_size;
	return r;
endfunction

// reads see the state before the write, then the write applies
function automatic void model_step(input lar_wr_cmd_t cmd, input lar_idx_t idx_a,
		input lar_idx_t idx_b, input lar_idx_t idx_c, output lar_rd_t exp_a,
		output lar_rd_t exp_b, output lar_rd_t exp_c, output lar_mem_wr_t exp_mem);
	lar_meta_t own;
	lar_shared_t old;
	lar_base_t base;
	lar_tag_t hit;
	lar_tag_t nt;
	logic ld;
	exp_a = model_read(idx_a);
	exp_b = model_read(idx_b);
	exp_c = model_read(idx_c);
	exp_mem = '0;
	if (!cmd.req || (cmd.index == '0))
	begin
		return;
	end
	own = m_meta[cmd.index];
	old = m_pool[own.tag];
	base = cmd.addr[LAR_ADDR_W-1:LAR_LINE_LSB];
	ld = (cmd.wr_type == WR_LOAD);
	hit = '0;
	for (int i = 1; i < LAR_NUM_DEFAULT; i++)
	begin
		if ((m_pool[i].ref_cnt != '0) && (m_pool[i].base == base))
		begin
			hit = lar_tag_t'(i);
		end
	end
	// data-only writes
	if ((cmd.wr_type == WR_ONLY_DATA) || (cmd.wr_type == WR_DATA_AND_TYPE))
	begin
		if (own.tag == '0)
		begin
			return;
		end
		if (old.data != cmd.data)
		begin
			m_pool[own.tag].dirty = 1'b1;
		end
		m_pool[own.tag].data = cmd.data;
		if (cmd.wr_type == WR_DATA_AND_TYPE)
		begin
			m_meta[cmd.index].data_type = cmd.data_type;
			m_meta[cmd.index].int_size = cmd.int_size;
		end
		return;
	end
	m_meta[cmd.index].addr = cmd.addr;
	m_meta[cmd.index].data_type = cmd.data_type;
	m_meta[cmd.index].int_size = cmd.int_size;
	if ((hit != '0) && (hit != own.tag))
	begin
		m_meta[cmd.index].tag = hit;
		m_pool[hit].ref_cnt = m_pool[hit].ref_cnt + 1'b1;
		m_pool[hit].data = ld ? cmd.data : old.data;
		m_pool[hit].dirty = !ld;
		if (old.ref_cnt == 1)
		begin
			m_ptr = m_ptr + 1'b1;
			m_stack[m_ptr] = own.tag;
			m_pool[own.tag].ref_cnt = '0;
			m_pool[own.tag].dirty = 1'b0;
			exp_mem = old.dirty ? {1'b1, old.data, old.base} : '0;
		end
		else if (old.ref_cnt > 1)
		begin
			m_pool[own.tag].ref_cnt = old.ref_cnt - 1'b1;
		end
	end
	else if ((hit != '0) && ld)
	begin
		m_pool[own.tag].data = cmd.data;
		m_pool[own.tag].dirty = 1'b0;
	end
	else if ((hit == '0) && (old.ref_cnt == 1))
	begin
		exp_mem = ((old.base != base) && old.dirty) ? {1'b1, old.data, old.base} : '0;
		m_pool[own.tag].base = base;
		m_pool[own.tag].data = ld ? cmd.data : old.data;
		m_pool[own.tag].dirty = !ld;
	end
	else if (hit == '0)
	begin
		nt = m_stack[m_ptr];
		m_ptr = m_ptr - 1'b1;
		m_meta[cmd.index].tag = nt;
		m_pool[nt].base = base;
		m_pool[nt].ref_cnt = lar_ref_t'(1);
		m_pool[nt].data = ld ? cmd.data : old.data;
		m_pool[nt].dirty = !ld;
		if (old.ref_cnt > 1)
		begin
			m_pool[own.tag].ref_cnt = old.ref_cnt - 1'b1;
		end
	end
endfunction

`endif

/* bench/lar_file_tb.sv */
`timescale 1ns/1ps

module lar_file_tb;
	import lar_file_pkg::*;

	`include "lar_file_model.svh"

	localparam int reset_cycles = 8;
	localparam int directed_cycles = 40;
	localparam int random_writes = 400;
	// four times the expected run length
	localparam int limit_cycles = 4 * (reset_cycles + directed_cycles + random_writes);

	// expected outputs for one cycle
	typedef struct packed {
		lar_rd_t a;
		lar_rd_t b;
		lar_rd_t c;
		lar_mem_wr_t m;
	} want_t;

	logic clk;
	logic rst_n;
	lar_idx_t rd_idx_a;
	lar_idx_t rd_idx_b;
	lar_idx_t rd_idx_c;
	lar_wr_cmd_t wr_cmd;
	lar_rd_t rd_a;
	lar_rd_t rd_b;
	lar_rd_t rd_c;
	lar_mem_wr_t mem_wr;

	want_t want_q [$];
	want_t cmp_w;
	logic [31:0] lfsr_q;
	int err_cnt;
	int chk_cnt;
	int wb_cnt;
	int cyc_cnt;

	lar_file_top #(.num_lars(LAR_NUM_DEFAULT)) dut_i (
		.clk(clk),
		.rst_n_i(rst_n),
		.rd_idx_a_i(rd_idx_a),
		.rd_idx_b_i(rd_idx_b),
		.rd_idx_c_i(rd_idx_c),
		.wr_cmd_i(wr_cmd),
		.rd_a_o(rd_a),
		.rd_b_o(rd_b),
		.rd_c_o(rd_c),
		.mem_wr_o(mem_wr)
	);

	always #2 clk = ~clk;

	// Galois form with taps x^32 + x^30 + x^26 + x^25 + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
		begin
			return (s >> 1) ^ 32'hA300_0000;
		end
		return s >> 1;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return r;
	endfunction

	function automatic lar_data_t rand_data();
		lar_data_t d;
		for (int k = 0; k < LAR_DATA_W / 32; k++)
		begin
			d[k*32 +: 32] = rand_bits(32);
		end
		return d;
	endfunction

	function automatic lar_wr_cmd_t make_cmd(input lar_write_type_e t, input lar_idx_t idx,
			input lar_data_t d, input lar_addr_t a, input lar_dtype_t dt, input lar_isize_t isz);
		lar_wr_cmd_t c;
		c.req = 1'b1;
		c.wr_type = t;
		c.index = idx;
		c.data = d;
		c.addr = a;
		c.data_type = dt;
		c.int_size = isz;
		return c;
	endfunction

	// drive one cycle on the falling edge and queue what the model expects
	task automatic drive_cycle(input lar_wr_cmd_t cmd, input lar_idx_t a, input lar_idx_t b,
			input lar_idx_t c);
		want_t w;
		lar_rd_t wa;
		lar_rd_t wb;
		lar_rd_t wc;
		lar_mem_wr_t wm;
		wr_cmd = cmd;
		rd_idx_a = a;
		rd_idx_b = b;
		rd_idx_c = c;
		model_step(cmd, a, b, c, wa, wb, wc, wm);
		w.a = wa;
		w.b = wb;
		w.c = wc;
		w.m = wm;
		want_q.push_back(w);
		@(negedge clk);
	endtask

	// idle once and wait until every queued result is compared
	task automatic drain();
		drive_cycle('0, 4'd0, 4'd0, 4'd0);
		while (want_q.size() != 0)
		begin
			@(negedge clk);
		end
	endtask

	task automatic check_rd(input string name, input lar_rd_t got, input lar_rd_t want);
		chk_cnt++;
		assert (got == want)
		else
		begin
			err_cnt++;
			$display("MISMATCH %s got %h exp %h", name, got, want);
		end
	endtask

	task automatic run_directed();
		lar_data_t d1;
		lar_data_t d2;
		lar_data_t d3;
		lar_data_t d4;
		d1 = {8{32'h1111_0001}};
		d2 = {8{32'h2222_0002}};
		d3 = {8{32'h3333_0003}};
		d4 = {8{32'h4444_0004}};
		// reset state on all ports and no write-back
		repeat (3) drive_cycle('0, 4'd0, 4'd1, 4'd2);
		// two lines get tags 15 then 14
		drive_cycle(make_cmd(WR_LOAD, 4'd1, d1, 64'h1000, 2'd1, 2'd0), 4'd1, 4'd2, 4'd1);
		drive_cycle(make_cmd(WR_LOAD, 4'd2, d2, 64'h2040, 2'd2, 2'd1), 4'd1, 4'd1, 4'd1);
		drive_cycle('0, 4'd2, 4'd2, 4'd2);
		// LAR 0 is fixed and LAR 5 has no entry yet
		drive_cycle(make_cmd(WR_LOAD, 4'd0, d3, 64'h5000, 2'd1, 2'd1), 4'd0, 4'd1, 4'd2);
		drive_cycle(make_cmd(WR_ONLY_DATA, 4'd5, d3, 64'h0, 2'd0, 2'd0), 4'd5, 4'd0, 4'd1);
		drive_cycle('0, 4'd0, 4'd5, 4'd2);
		// store lands on LAR 1's line and shares tag 15
		drive_cycle(make_cmd(WR_STORE, 4'd3, d4, 64'h1008, 2'd3, 2'd3), 4'd1, 4'd3, 4'd0);
		drive_cycle('0, 4'd1, 4'd3, 4'd0);
		// LAR 3 sees the load through the shared entry
		drive_cycle(make_cmd(WR_LOAD, 4'd1, d3, 64'h1010, 2'd1, 2'd0), 4'd1, 4'd3, 4'd2);
		drive_cycle('0, 4'd1, 4'd3, 4'd2);
		// new type and data leave LAR 2 dirty
		drive_cycle(make_cmd(WR_DATA_AND_TYPE, 4'd2, d4, 64'h0, 2'd3, 2'd2), 4'd2, 4'd2, 4'd2);
		drive_cycle('0, 4'd2, 4'd1, 4'd3);
		// sole owner moves away and the dirty line goes out
		drive_cycle(make_cmd(WR_LOAD, 4'd2, d1, 64'h3000, 2'd3, 2'd2), 4'd2, 4'd1, 4'd3);
		drive_cycle('0, 4'd2, 4'd1, 4'd3);
		// clean this time so nothing goes back
		drive_cycle(make_cmd(WR_LOAD, 4'd2, d2, 64'h4000, 2'd0, 2'd1), 4'd2, 4'd1, 4'd3);
		repeat (2) drive_cycle('0, 4'd2, 4'd3, 4'd1);
		drain();
		assert (wb_cnt == 1)
		else
		begin
			err_cnt++;
			$display("directed tests expected one write-back request but saw %0d", wb_cnt);
		end
	endtask

	task automatic run_random();
		lar_wr_cmd_t cmd;
		lar_idx_t a;
		lar_idx_t b;
		lar_idx_t c;
		for (int n = 0; n < random_writes; n++)
		begin
			cmd.req = (rand_bits(3) != 32'd0);
			cmd.wr_type = lar_write_type_e'(2'(rand_bits(2)));
			cmd.index = lar_idx_t'(rand_bits(4));
			// eight lines from 0x1000 up with varying offset bits
			cmd.addr = 64'h1000 | (lar_addr_t'(rand_bits(3)) << 5) | lar_addr_t'(rand_bits(5));
			// small data set so unchanged writes happen
			if (rand_bits(1) != 32'd0)
			begin
				cmd.data = rand_data();
			end
			else
			begin
				cmd.data = {8{rand_bits(2)}};
			end
			cmd.data_type = lar_dtype_t'(rand_bits(2));
			cmd.int_size = lar_isize_t'(rand_bits(2));
			a = lar_idx_t'(rand_bits(4));
			b = lar_idx_t'(rand_bits(4));
			c = lar_idx_t'(rand_bits(4));
			drive_cycle(cmd, a, b, c);
		end
	endtask

	// outputs settle just after the rising edge while inputs move at the falling edge
	always @(posedge clk)
	begin
		#1;
		if (want_q.size() != 0)
		begin
			cmp_w = want_q.pop_front();
			check_rd("rd_a_o", rd_a, cmp_w.a);
			check_rd("rd_b_o", rd_b, cmp_w.b);
			check_rd("rd_c_o", rd_c, cmp_w.c);
			chk_cnt++;
			assert (mem_wr == cmp_w.m)
			else
			begin
				err_cnt++;
				$display("MISMATCH mem_wr_o got %h exp %h", mem_wr, cmp_w.m);
			end
			if (mem_wr.req)
			begin
				wb_cnt++;
			end
		end
	end

	always @(posedge clk)
	begin
		cyc_cnt++;
		if (cyc_cnt > limit_cycles)
		begin
			$display("timeout after %0d cycles, the run did not finish", cyc_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		rd_idx_a = '0;
		rd_idx_b = '0;
		rd_idx_c = '0;
		wr_cmd = '0;
		lfsr_q = 32'h84438e49;
		err_cnt = 0;
		chk_cnt = 0;
		wb_cnt = 0;
		cyc_cnt = 0;
		model_reset();
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		run_directed();
		run_random();
		drain();
		$display("checks %0d, errors %0d, write-backs %0d", chk_cnt, err_cnt, wb_cnt);
		if (err_cnt == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* bench/lar_file_checker.sv */
`timescale 1ns/1ps

module lar_file_checker (
	input logic clk,
	input logic rst_n_i,
	input lar_file_pkg::lar_rd_t rd_a_o,
	input lar_file_pkg::lar_rd_t rd_b_o,
	input lar_file_pkg::lar_rd_t rd_c_o,
	input lar_file_pkg::lar_mem_wr_t mem_wr_o
);
	import lar_file_pkg::*;

	logic tag0_data_ok;
	logic tag0_addr_ok;

	// tag 0 is the empty entry whose data stays zero
	assign tag0_data_ok = ((rd_a_o.tag != '0) || (rd_a_o.data == '0))
		&& ((rd_b_o.tag != '0) || (rd_b_o.data == '0))
		&& ((rd_c_o.tag != '0) || (rd_c_o.data == '0));

	// only load and store set an address and both always give a tag
	assign tag0_addr_ok = ((rd_a_o.tag != '0) || (rd_a_o.addr == '0))
		&& ((rd_b_o.tag != '0) || (rd_b_o.addr == '0))
		&& ((rd_c_o.tag != '0) || (rd_c_o.addr == '0));

	// nothing can be pending straight out of reset
	a_no_wb_after_rst: assert property (@(posedge clk) $rose(rst_n_i) |=> !mem_wr_o.req)
		else $error("write-back request in the first cycle after reset");

	a_tag0_data: assert property (@(posedge clk) disable iff (!rst_n_i) tag0_data_ok)
		else $error("read result with tag 0 carries nonzero data");

	a_tag0_addr: assert property (@(posedge clk) disable iff (!rst_n_i) tag0_addr_ok)
		else $error("read result with tag 0 carries a nonzero address");

endmodule

bind lar_file_top lar_file_checker chk_i (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.rd_a_o(rd_a_o),
	.rd_b_o(rd_b_o),
	.rd_c_o(rd_c_o),
	.mem_wr_o(mem_wr_o)
);

/* src/lar_file_top.sv */
`timescale 1ns/1ps

module lar_file_top #(
	parameter int num_lars = lar_file_pkg::LAR_NUM_DEFAULT
) (
	input logic clk,
	input logic rst_n_i,
	input logic [$clog2(num_lars)-1:0] rd_idx_a_i,
	input logic [$clog2(num_lars)-1:0] rd_idx_b_i,
	input logic [$clog2(num_lars)-1:0] rd_idx_c_i,
	input lar_file_pkg::lar_wr_cmd_t wr_cmd_i,
	output lar_file_pkg::lar_rd_t rd_a_o,
	output lar_file_pkg::lar_rd_t rd_b_o,
	output lar_file_pkg::lar_rd_t rd_c_o,
	output lar_file_pkg::lar_mem_wr_t mem_wr_o
);
	import lar_file_pkg::*;

	localparam int tag_w = $clog2(num_lars);

	// metadata side
	lar_meta_t wr_meta;
	lar_meta_upd_t meta_upd;

	// shared pool side
	lar_shared_upd_t upd_tgt;
	lar_shared_upd_t upd_old;
	lar_shared_t [num_lars-1:0] pool;
	lar_shared_t wr_entry;
	lar_shared_t [LAR_RD_PORTS-1:0] rd_entries;
	logic [LAR_RD_PORTS-1:0][tag_w-1:0] rd_tags;

	// tag allocation
	logic [tag_w-1:0] hit_tag;
	logic [tag_w-1:0] top_tag;
	logic [tag_w-1:0] push_tag;
	logic pop;
	logic push;

	lar_metadata_file #(.num_lars(num_lars)) meta_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.meta_upd_i(meta_upd),
		.rd_idx_a_i(rd_idx_a_i),
		.rd_idx_b_i(rd_idx_b_i),
		.rd_idx_c_i(rd_idx_c_i),
		.wr_idx_i(wr_cmd_i.index),
		.rd_entries_i(rd_entries),
		.wr_meta_o(wr_meta),
		.rd_tags_o(rd_tags),
		.rd_a_o(rd_a_o),
		.rd_b_o(rd_b_o),
		.rd_c_o(rd_c_o)
	);

	// write tag comes straight from the written LAR's metadata
	lar_shared_store #(.num_lars(num_lars)) store_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.upd_tgt_i(upd_tgt),
		.upd_old_i(upd_old),
		.wr_tag_i(wr_meta.tag),
		.rd_tags_i(rd_tags),
		.pool_o(pool),
		.wr_entry_o(wr_entry),
		.rd_entries_o(rd_entries)
	);

	lar_tag_search #(.num_lars(num_lars)) search_i (
		.wr_cmd_i(wr_cmd_i),
		.pool_i(pool),
		.hit_tag_o(hit_tag)
	);

	lar_tag_stack #(.num_lars(num_lars)) stack_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.pop_i(pop),
		.push_i(push),
		.push_tag_i(push_tag),
		.top_tag_o(top_tag)
	);

	lar_write_ctrl #(.num_lars(num_lars)) ctrl_i (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.wr_cmd_i(wr_cmd_i),
		.wr_meta_i(wr_meta),
		.wr_entry_i(wr_entry),
		.hit_tag_i(hit_tag),
		.top_tag_i(top_tag),
		.meta_upd_o(meta_upd),
		.upd_tgt_o(upd_tgt),
		.upd_old_o(upd_old),
		.pop_o(pop),
		.push_o(push),
		.push_tag_o(push_tag),
		.mem_wr_o(mem_wr_o)
	);

endmodule

/* src/lar_write_ctrl.sv */
`timescale 1ns/1ps

module lar_write_ctrl #(
	parameter int num_lars = lar_file_pkg::LAR_NUM_DEFAULT
) (
	input logic clk,
	input logic rst_n_i,
	input lar_file_pkg::lar_wr_cmd_t wr_cmd_i,
	input lar_file_pkg::lar_meta_t wr_meta_i,
	input lar_file_pkg::lar_shared_t wr_entry_i,
	input logic [$clog2(num_lars)-1:0] hit_tag_i,
	input logic [$clog2(num_lars)-1:0] top_tag_i,
	output lar_file_pkg::lar_meta_upd_t meta_upd_o,
	output lar_file_pkg::lar_shared_upd_t upd_tgt_o,
	output lar_file_pkg::lar_shared_upd_t upd_old_o,
	output logic pop_o,
	output logic push_o,
	output logic [$clog2(num_lars)-1:0] push_tag_o,
	output lar_file_pkg::lar_mem_wr_t mem_wr_o
);
	import lar_file_pkg::*;

	localparam int tag_w = $clog2(num_lars);

	logic wr_en;
	logic is_load;
	logic own_sole;
	logic wb_req;
	lar_base_t in_base;
	logic [tag_w-1:0] own_tag;
	lar_mem_wr_t mem_wr_q;

	// LAR 0 is hard-wired
	assign wr_en = wr_cmd_i.req && (wr_cmd_i.index != '0);
	assign is_load = (wr_cmd_i.wr_type == WR_LOAD);
	assign in_base = wr_cmd_i.addr[LAR_ADDR_W-1:LAR_LINE_LSB];
	assign own_tag = wr_meta_i.tag;
	// this LAR is the only reference to its entry
	assign own_sole = (wr_entry_i.ref_cnt == lar_ref_t'(1));

	always_comb
	begin
		meta_upd_o = '0;
		upd_tgt_o = '0;
		upd_old_o = '0;
		pop_o = 1'b0;
		push_o = 1'b0;
		wb_req = 1'b0;
		// a released tag is always the own one
		push_tag_o = own_tag;

		// values fixed, set bits pick what lands
		meta_upd_o.idx = wr_cmd_i.index;
		meta_upd_o.addr = wr_cmd_i.addr;
		meta_upd_o.data_type = wr_cmd_i.data_type;
		meta_upd_o.int_size = wr_cmd_i.int_size;
		upd_old_o.tag = own_tag;

		if (wr_en)
		begin
			case (wr_cmd_i.wr_type)
			WR_ONLY_DATA, WR_DATA_AND_TYPE:
			begin
				// unallocated LAR has nothing to write into
				if (own_tag != '0)
				begin
					upd_old_o.en = 1'b1;
					upd_old_o.set_data = 1'b1;
					upd_old_o.data = wr_cmd_i.data;
					// same data keeps memory in sync
					if (wr_entry_i.data != wr_cmd_i.data)
					begin
						upd_old_o.set_dirty = 1'b1;
						upd_old_o.dirty = 1'b1;
					end
					if (wr_cmd_i.wr_type == WR_DATA_AND_TYPE)
					begin
						meta_upd_o.en = 1'b1;
						meta_upd_o.set_type = 1'b1;
					end
				end
			end
			default:
			begin
				// load or store, address and type always land
				meta_upd_o.en = 1'b1;
				meta_upd_o.set_addr = 1'b1;
				meta_upd_o.set_type = 1'b1;

				if ((hit_tag_i != '0) && (hit_tag_i != own_tag))
				begin
					// alias another live entry
					meta_upd_o.set_tag = 1'b1;
					meta_upd_o.tag = hit_tag_i;
					upd_tgt_o.en = 1'b1;
					upd_tgt_o.tag = hit_tag_i;
					upd_tgt_o.set_ref = 1'b1;
					upd_tgt_o.ref_delta = lar_ref_t'(1);
					upd_tgt_o.set_data = 1'b1;
					upd_tgt_o.set_dirty = 1'b1;
					// store carries own data over, dirty
					upd_tgt_o.data = is_load ? wr_cmd_i.data : wr_entry_i.data;
					upd_tgt_o.dirty = !is_load;

					// drop the old reference if there was one
					if (wr_entry_i.ref_cnt != '0)
					begin
						upd_old_o.en = 1'b1;
						upd_old_o.set_ref = 1'b1;
						upd_old_o.ref_delta = '1;
					end
					// last reference gone, free the tag
					if (own_sole)
					begin
						push_o = 1'b1;
						upd_old_o.set_dirty = 1'b1;
						upd_old_o.dirty = 1'b0;
						wb_req = wr_entry_i.dirty;
					end
				end
				else if (hit_tag_i != '0)
				begin
					// hit on own entry, only a load changes it
					if (is_load)
					begin
						upd_old_o.en = 1'b1;
						upd_old_o.set_data = 1'b1;
						upd_old_o.data = wr_cmd_i.data;
						upd_old_o.set_dirty = 1'b1;
						upd_old_o.dirty = 1'b0;
					end
				end
				else if (own_sole)
				begin
					// no alias, retarget own entry in place
					upd_old_o.en = 1'b1;
					upd_old_o.set_base = 1'b1;
					upd_old_o.base = in_base;
					upd_old_o.set_dirty = 1'b1;
					upd_old_o.dirty = !is_load;
					upd_old_o.set_data = is_load;
					upd_old_o.data = wr_cmd_i.data;
					// old line leaves, flush if modified
					wb_req = (wr_entry_i.base != in_base) && wr_entry_i.dirty;
				end
				else
				begin
					// no alias and entry unowned or shared
					// allocate a fresh tag from the stack
					pop_o = 1'b1;
					meta_upd_o.set_tag = 1'b1;
					meta_upd_o.tag = top_tag_i;
					upd_tgt_o.en = 1'b1;
					upd_tgt_o.tag = top_tag_i;
					upd_tgt_o.set_base = 1'b1;
					upd_tgt_o.base = in_base;
					upd_tgt_o.set_ref = 1'b1;
					upd_tgt_o.ref_delta = lar_ref_t'(1);
					upd_tgt_o.set_data = 1'b1;
					upd_tgt_o.set_dirty = 1'b1;
					upd_tgt_o.dirty = !is_load;
					if (is_load)
					begin
						upd_tgt_o.data = wr_cmd_i.data;
					end
					else if (wr_entry_i.ref_cnt != '0)
					begin
						upd_tgt_o.data = wr_entry_i.data;
					end
					// shared entry keeps its other users
					if (wr_entry_i.ref_cnt != '0)
					begin
						upd_old_o.en = 1'b1;
						upd_old_o.set_ref = 1'b1;
						upd_old_o.ref_delta = '1;
					end
				end
			end
			endcase
		end
	end

	// one-cycle write-back of the old entry
	// payload zero while idle
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			mem_wr_q <= '0;
		end
		else if (wb_req)
		begin
			mem_wr_q.req <= 1'b1;
			mem_wr_q.data <= wr_entry_i.data;
			mem_wr_q.base <= wr_entry_i.base;
		end
		else
		begin
			mem_wr_q <= '0;
		end
	end

	assign mem_wr_o = mem_wr_q;

endmodule

/* src/lar_metadata_file.sv */
`timescale 1ns/1ps

module lar_metadata_file #(
	parameter int num_lars = lar_file_pkg::LAR_NUM_DEFAULT
) (
	input logic clk,
	input logic rst_n_i,
	input lar_file_pkg::lar_meta_upd_t meta_upd_i,
	input logic [$clog2(num_lars)-1:0] rd_idx_a_i,
	input logic [$clog2(num_lars)-1:0] rd_idx_b_i,
	input logic [$clog2(num_lars)-1:0] rd_idx_c_i,
	input logic [$clog2(num_lars)-1:0] wr_idx_i,
	input lar_file_pkg::lar_shared_t [lar_file_pkg::LAR_RD_PORTS-1:0] rd_entries_i,
	output lar_file_pkg::lar_meta_t wr_meta_o,
	output logic [lar_file_pkg::LAR_RD_PORTS-1:0][$clog2(num_lars)-1:0] rd_tags_o,
	output lar_file_pkg::lar_rd_t rd_a_o,
	output lar_file_pkg::lar_rd_t rd_b_o,
	output lar_file_pkg::lar_rd_t rd_c_o
);
	import lar_file_pkg::*;

	localparam int idx_w = $clog2(num_lars);

	lar_meta_t [num_lars-1:0] meta_q;
	logic [idx_w-1:0] rd_idx [LAR_RD_PORTS];
	lar_rd_t rd_q [LAR_RD_PORTS];

	// merge metadata with the data of its tag
	function automatic lar_rd_t make_rd(lar_meta_t m, lar_shared_t s);
		lar_rd_t r;
		r.data = s.data;
		r.addr = m.addr;
		r.tag = m.tag;
		r.data_type = m.data_type;
		r.int_size = m.int_size;
		return r;
	endfunction

	// update fields come from the write controller
	// LAR 0 is never enabled there
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			meta_q <= '0;
		end
		else if (meta_upd_i.en)
		begin
			if (meta_upd_i.set_addr)
			begin
				meta_q[meta_upd_i.idx].addr <= meta_upd_i.addr;
			end
			if (meta_upd_i.set_tag)
			begin
				meta_q[meta_upd_i.idx].tag <= meta_upd_i.tag;
			end
			if (meta_upd_i.set_type)
			begin
				meta_q[meta_upd_i.idx].data_type <= meta_upd_i.data_type;
				meta_q[meta_upd_i.idx].int_size <= meta_upd_i.int_size;
			end
		end
	end

	// current metadata of the LAR being written
	assign wr_meta_o = meta_q[wr_idx_i];

	assign rd_idx[0] = rd_idx_a_i;
	assign rd_idx[1] = rd_idx_b_i;
	assign rd_idx[2] = rd_idx_c_i;

	// tags out to the store, entries come back in the same cycle
	// read result registered from state before this edge's write
	for (genvar k = 0; k < LAR_RD_PORTS; k++)
	begin : g_rd
		assign rd_tags_o[k] = meta_q[rd_idx[k]].tag;

		always_ff @(posedge clk)
		begin
			if (!rst_n_i)
			begin
				rd_q[k] <= '0;
			end
			else
			begin
				rd_q[k] <= make_rd(meta_q[rd_idx[k]], rd_entries_i[k]);
			end
		end
	end

	assign rd_a_o = rd_q[0];
	assign rd_b_o = rd_q[1];
	assign rd_c_o = rd_q[2];

endmodule

/* src/lar_shared_store.sv */
`timescale 1ns/1ps

module lar_shared_store #(
	parameter int num_lars = lar_file_pkg::LAR_NUM_DEFAULT
) (
	input logic clk,
	input logic rst_n_i,
	input lar_file_pkg::lar_shared_upd_t upd_tgt_i,
	input lar_file_pkg::lar_shared_upd_t upd_old_i,
	input logic [$clog2(num_lars)-1:0] wr_tag_i,
	input logic [lar_file_pkg::LAR_RD_PORTS-1:0][$clog2(num_lars)-1:0] rd_tags_i,
	output lar_file_pkg::lar_shared_t [num_lars-1:0] pool_o,
	output lar_file_pkg::lar_shared_t wr_entry_o,
	output lar_file_pkg::lar_shared_t [lar_file_pkg::LAR_RD_PORTS-1:0] rd_entries_o
);
	import lar_file_pkg::*;

	lar_shared_t [num_lars-1:0] pool_q;

	// apply the selected fields of one update
	function automatic lar_shared_t apply_upd(lar_shared_t cur, lar_shared_upd_t upd);
		lar_shared_t nxt;
		nxt = cur;
		if (upd.set_base)
		begin
			nxt.base = upd.base;
		end
		if (upd.set_data)
		begin
			nxt.data = upd.data;
		end
		// count moves by a delta
		if (upd.set_ref)
		begin
			nxt.ref_cnt = cur.ref_cnt + upd.ref_delta;
		end
		if (upd.set_dirty)
		begin
			nxt.dirty = upd.dirty;
		end
		return nxt;
	endfunction

	// target and old update always name different tags
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			pool_q <= '0;
		end
		else
		begin
			if (upd_tgt_i.en)
			begin
				pool_q[upd_tgt_i.tag] <= apply_upd(pool_q[upd_tgt_i.tag], upd_tgt_i);
			end
			if (upd_old_i.en)
			begin
				pool_q[upd_old_i.tag] <= apply_upd(pool_q[upd_old_i.tag], upd_old_i);
			end
		end
	end

	// whole pool for the alias search
	assign pool_o = pool_q;

	// entry currently owned by the written LAR
	assign wr_entry_o = pool_q[wr_tag_i];

	for (genvar k = 0; k < LAR_RD_PORTS; k++)
	begin : g_rd
		assign rd_entries_o[k] = pool_q[rd_tags_i[k]];
	end

endmodule

/* src/lar_tag_stack.sv */
`timescale 1ns/1ps

module lar_tag_stack #(
	parameter int num_lars = lar_file_pkg::LAR_NUM_DEFAULT
) (
	input logic clk,
	input logic rst_n_i,
	input logic pop_i,
	input logic push_i,
	input logic [$clog2(num_lars)-1:0] push_tag_i,
	output logic [$clog2(num_lars)-1:0] top_tag_o
);
	import lar_file_pkg::*;

	localparam int tag_w = $clog2(num_lars);

	logic [tag_w-1:0] stack_q [num_lars];
	// points at the next tag to hand out
	logic [tag_w-1:0] ptr_q;

	assign top_tag_o = stack_q[ptr_q];

	// slot i starts with tag i, pointer at the last slot
	// so the first allocation gets the highest tag
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < num_lars; i++)
			begin
				stack_q[i] <= tag_w'(i);
			end
			ptr_q <= tag_w'(num_lars - 1);
		end
		else if (push_i)
		begin
			// freed tag goes above the current top
			stack_q[ptr_q + 1'b1] <= push_tag_i;
			ptr_q <= ptr_q + 1'b1;
		end
		else if (pop_i)
		begin
			ptr_q <= ptr_q - 1'b1;
		end
	end

	// push and pop never come in the same cycle
	// a release frees a tag, an allocation takes one

endmodule

/* src/lar_tag_search.sv */
`timescale 1ns/1ps

module lar_tag_search #(
	parameter int num_lars = lar_file_pkg::LAR_NUM_DEFAULT
) (
	input lar_file_pkg::lar_wr_cmd_t wr_cmd_i,
	input lar_file_pkg::lar_shared_t [num_lars-1:0] pool_i,
	output logic [$clog2(num_lars)-1:0] hit_tag_o
);
	import lar_file_pkg::*;

	localparam int tag_w = $clog2(num_lars);

	lar_base_t in_base;

	// base address of the incoming write
	assign in_base = wr_cmd_i.addr[LAR_ADDR_W-1:LAR_LINE_LSB];

	// live entries hold distinct bases so at most one matches
	// entry 0 is the unallocated tag and never takes part
	always_comb
	begin
		hit_tag_o = '0;
		for (int i = 1; i < num_lars; i++)
		begin
			if ((pool_i[i].ref_cnt != '0) && (pool_i[i].base == in_base))
			begin
				hit_tag_o = hit_tag_o | tag_w'(i);
			end
		end
	end

endmodule

/* src/lar_file_pkg.sv */
package lar_file_pkg;

	// default LAR count, also the shared pool depth
	localparam int LAR_NUM_DEFAULT = 16;
	localparam int LAR_RD_PORTS = 3;

	localparam int LAR_DATA_W = 256;
	localparam int LAR_ADDR_W = 64;
	// lowest address bit that is part of the base address
	localparam int LAR_LINE_LSB = 5;
	localparam int LAR_BASE_W = LAR_ADDR_W - LAR_LINE_LSB;

	// fixed for the default of 16 LARs
	localparam int LAR_TAG_W = 4;
	localparam int LAR_DTYPE_W = 2;
	localparam int LAR_ISIZE_W = 2;

	typedef logic [LAR_TAG_W-1:0] lar_idx_t;
	typedef logic [LAR_TAG_W-1:0] lar_tag_t;
	typedef logic [LAR_TAG_W-1:0] lar_ref_t;
	typedef logic [LAR_DATA_W-1:0] lar_data_t;
	typedef logic [LAR_ADDR_W-1:0] lar_addr_t;
	typedef logic [LAR_BASE_W-1:0] lar_base_t;
	typedef logic [LAR_DTYPE_W-1:0] lar_dtype_t;
	typedef logic [LAR_ISIZE_W-1:0] lar_isize_t;

	typedef enum logic [1:0] {
		WR_ONLY_DATA,
		WR_DATA_AND_TYPE,
		WR_LOAD,
		WR_STORE
	} lar_write_type_e;

	// write command from the CPU, one-cycle strobe in req
	typedef struct packed {
		logic req;
		lar_write_type_e wr_type;
		lar_idx_t index;
		lar_data_t data;
		lar_addr_t addr;
		lar_dtype_t data_type;
		lar_isize_t int_size;
	} lar_wr_cmd_t;

	typedef struct packed {
		lar_addr_t addr;
		lar_tag_t tag;
		lar_dtype_t data_type;
		lar_isize_t int_size;
	} lar_meta_t;

	typedef struct packed {
		lar_base_t base;
		lar_data_t data;
		lar_ref_t ref_cnt;
		logic dirty;
	} lar_shared_t;

	// field-masked update of one shared entry
	// ref_delta is added to the count, never loaded
	typedef struct packed {
		logic en;
		lar_tag_t tag;
		logic set_base;
		lar_base_t base;
		logic set_data;
		lar_data_t data;
		logic set_ref;
		lar_ref_t ref_delta;
		logic set_dirty;
		logic dirty;
	} lar_shared_upd_t;

	// set_type covers both data type and int size
	typedef struct packed {
		logic en;
		lar_idx_t idx;
		logic set_addr;
		lar_addr_t addr;
		logic set_tag;
		lar_tag_t tag;
		logic set_type;
		lar_dtype_t data_type;
		lar_isize_t int_size;
	} lar_meta_upd_t;

	typedef struct packed {
		lar_data_t data;
		lar_addr_t addr;
		lar_tag_t tag;
		lar_dtype_t data_type;
		lar_isize_t int_size;
	} lar_rd_t;

	// write-back to memory, no back-pressure
	typedef struct packed {
		logic req;
		lar_data_t data;
		lar_base_t base;
	} lar_mem_wr_t;

endpackage
